// File: logic/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

// Opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type funct codes
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_SLT   6'h2a
`define FN_JR    6'h08
`define FN_BREAK 6'h0d
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_SRA   6'h03

// Cycles per phase
`define FETCH_STEPS  4
`define DECODE_STEPS 3
`define ALU_STEPS    3
`define MEM_STEPS    4
`define SHIFT_STEPS  2

`endif

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

`include "ctrl_config.svh"

    typedef logic [`OPCODE_W-1:0] opcode_t;
    typedef logic [`FUNCT_W-1:0]  funct_t;
    typedef logic [2:0]           step_t;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_PASS = 3'd0;
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_SUB  = 3'd2;
    localparam alu_op_t ALU_AND  = 3'd3;
    localparam alu_op_t ALU_SLT  = 3'd7;

    typedef logic [2:0] shift_op_t;
    localparam shift_op_t SH_NOP         = 3'd0;
    localparam shift_op_t SH_LOAD        = 3'd1;
    localparam shift_op_t SH_LEFT        = 3'd2;
    localparam shift_op_t SH_RIGHT_LOG   = 3'd3;
    localparam shift_op_t SH_RIGHT_ARITH = 3'd4;

    typedef logic [1:0] src_b_t;
    localparam src_b_t SB_REG    = 2'd0;
    localparam src_b_t SB_FOUR   = 2'd1;
    localparam src_b_t SB_IMM    = 2'd2;
    localparam src_b_t SB_BRANCH = 2'd3;

    typedef logic [1:0] reg_dst_t;
    localparam reg_dst_t RD_RT = 2'd0;
    localparam reg_dst_t RD_RD = 2'd1;

    typedef logic [2:0] pc_src_t;
    localparam pc_src_t PC_ALU = 3'd1;

    typedef logic [2:0] data_src_t;
    localparam data_src_t DS_ALUOUT = 3'd1;
    localparam data_src_t DS_MDR    = 3'd2;
    localparam data_src_t DS_SHIFT  = 3'd4;
    localparam data_src_t DS_SLT    = 3'd6;

    typedef enum logic [3:0] {
        CL_ADD, CL_SUB, CL_AND, CL_SLT, CL_ADDI, CL_JR, CL_BREAK,
        CL_SLL, CL_SRL, CL_SRA, CL_LW, CL_SW, CL_UNKNOWN
    } instr_class_e;

    typedef enum logic [4:0] {
        ST_RESET, ST_FETCH, ST_DECODE, ST_ADD, ST_SUB, ST_AND, ST_SLT,
        ST_ADDI, ST_JR, ST_BREAK, ST_SHIFT_SETUP, ST_SLL, ST_SRL, ST_SRA,
        ST_LW, ST_SW, ST_CLOSE
    } ctrl_state_e;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instr_fields_t;

    typedef struct packed {
        // Write strobes
        logic      pc_w;
        logic      mem_w;
        logic      ir_w;
        logic      reg_w;
        logic      reg_ab_w;
        logic      alu_out_w;
        logic      mdr_w;
        // Datapath selects
        logic      alu_src_a;
        src_b_t    alu_src_b;
        reg_dst_t  reg_dst;
        pc_src_t   pc_src;
        data_src_t data_src;
        logic [2:0] i_or_d;
        // Unit operations
        alu_op_t   alu_op;
        shift_op_t shift_op;
    } ctrl_word_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

`include "ctrl_config.svh"

module instr_decoder import ctrl_pkg::*; (
    input  instr_fields_t i_fields,
    output instr_class_e  o_class
);

    instr_class_e rtype_class;

    // R-type instructions are told apart by funct alone
    always_comb begin
        case (i_fields.funct)
            `FN_ADD:   rtype_class = CL_ADD;
            `FN_SUB:   rtype_class = CL_SUB;
            `FN_AND:   rtype_class = CL_AND;
            `FN_SLT:   rtype_class = CL_SLT;
            `FN_JR:    rtype_class = CL_JR;
            `FN_BREAK: rtype_class = CL_BREAK;
            `FN_SLL:   rtype_class = CL_SLL;
            `FN_SRL:   rtype_class = CL_SRL;
            `FN_SRA:   rtype_class = CL_SRA;
            default:   rtype_class = CL_UNKNOWN;
        endcase
    end

    always_comb begin
        case (i_fields.opcode)
            `OP_RTYPE: begin
                o_class = rtype_class;
            end
            `OP_ADDI: begin
                o_class = CL_ADDI;
            end
            `OP_LW: begin
                o_class = CL_LW;
            end
            `OP_SW: begin
                o_class = CL_SW;
            end
            default: begin
                o_class = CL_UNKNOWN;
            end
        endcase
    end

endmodule

// File: logic/step_sequencer.sv
`timescale 1ns/1ps

`include "ctrl_config.svh"

module step_sequencer import ctrl_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_class_e i_class,
    output ctrl_state_e  o_state,
    output step_t        o_step,
    output logic         o_cpu_reset
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    ctrl_state_e decoded_state;
    ctrl_state_e shift_target;
    step_t       step;
    step_t       phase_len;
    logic        last_step;

    // Cycles spent in each state
    always_comb begin
        case (state)
            ST_FETCH:                        phase_len = step_t'(`FETCH_STEPS);
            ST_DECODE:                       phase_len = step_t'(`DECODE_STEPS);
            ST_ADD, ST_SUB, ST_AND, ST_ADDI: phase_len = step_t'(`ALU_STEPS);
            // slt writes the flag back directly, no ALUOut cycle
            ST_SLT:                          phase_len = step_t'(`ALU_STEPS - 1);
            ST_SLL, ST_SRL, ST_SRA:          phase_len = step_t'(`SHIFT_STEPS);
            ST_LW, ST_SW:                    phase_len = step_t'(`MEM_STEPS);
            default:                         phase_len = step_t'(1);
        endcase
    end

    assign last_step = (step == phase_len - step_t'(1));

    // Execute entry for the decoded class
    always_comb begin
        case (i_class)
            CL_ADD:                 decoded_state = ST_ADD;
            CL_SUB:                 decoded_state = ST_SUB;
            CL_AND:                 decoded_state = ST_AND;
            CL_SLT:                 decoded_state = ST_SLT;
            CL_ADDI:                decoded_state = ST_ADDI;
            CL_JR:                  decoded_state = ST_JR;
            CL_BREAK:               decoded_state = ST_BREAK;
            CL_SLL, CL_SRL, CL_SRA: decoded_state = ST_SHIFT_SETUP;
            CL_LW:                  decoded_state = ST_LW;
            CL_SW:                  decoded_state = ST_SW;
            default:                decoded_state = ST_CLOSE;
        endcase
    end

    always_comb begin
        case (state)
            ST_RESET:       next_state = ST_FETCH;
            ST_FETCH:       next_state = ST_DECODE;
            ST_DECODE:      next_state = decoded_state;
            ST_SHIFT_SETUP: next_state = shift_target;
            ST_BREAK:       next_state = ST_BREAK;
            ST_CLOSE:       next_state = ST_FETCH;
            default:        next_state = ST_CLOSE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            step  <= '0;
        end else if (state == ST_BREAK) begin
            // Halted until reset, step stays past the pc_w cycle
            step <= step_t'(1);
        end else if (last_step) begin
            state <= next_state;
            step  <= '0;
        end else begin
            step <= step + step_t'(1);
        end
    end

    // Shift direction latched with the class at end of decode
    always_ff @(posedge clk) begin
        if (state == ST_DECODE && last_step) begin
            case (i_class)
                CL_SRL:  shift_target <= ST_SRL;
                CL_SRA:  shift_target <= ST_SRA;
                default: shift_target <= ST_SLL;
            endcase
        end
    end

    assign o_state     = state;
    assign o_step      = step;
    assign o_cpu_reset = reset || (state == ST_RESET);

endmodule

// File: logic/ctrl_word_encoder.sv
`timescale 1ns/1ps

`include "ctrl_config.svh"

module ctrl_word_encoder import ctrl_pkg::*; (
    input  ctrl_state_e i_state,
    input  step_t       i_step,
    output ctrl_word_t  o_ctrl
);

    localparam step_t FETCH_LAST = step_t'(`FETCH_STEPS - 1);
    localparam step_t ALU_LAST   = step_t'(`ALU_STEPS - 1);
    localparam step_t MEM_LAST   = step_t'(`MEM_STEPS - 1);
    localparam step_t SHIFT_LAST = step_t'(`SHIFT_STEPS - 1);

    alu_op_t   alu_fn;
    shift_op_t shift_dir;

    // Operation per execute state
    always_comb begin
        case (i_state)
            ST_SUB:  alu_fn = ALU_SUB;
            ST_AND:  alu_fn = ALU_AND;
            default: alu_fn = ALU_ADD;
        endcase
    end

    always_comb begin
        case (i_state)
            ST_SRL:  shift_dir = SH_RIGHT_LOG;
            ST_SRA:  shift_dir = SH_RIGHT_ARITH;
            default: shift_dir = SH_LEFT;
        endcase
    end

    always_comb begin
        o_ctrl = '0;
        case (i_state)
            ST_FETCH: begin
                if (i_step == FETCH_LAST) begin
                    o_ctrl.ir_w      = 1'b1;
                    o_ctrl.pc_w      = 1'b1;
                    o_ctrl.pc_src    = PC_ALU;
                    o_ctrl.alu_src_b = SB_FOUR;
                    o_ctrl.alu_op    = ALU_ADD;
                end
            end
            ST_DECODE: begin
                if (i_step == '0) begin
                    o_ctrl.reg_ab_w  = 1'b1;
                    o_ctrl.alu_out_w = 1'b1;
                    o_ctrl.alu_src_b = SB_BRANCH;
                end
            end
            ST_ADD, ST_SUB, ST_AND, ST_ADDI: begin
                o_ctrl.alu_src_a = 1'b1;
                o_ctrl.alu_op    = alu_fn;
                if (i_state == ST_ADDI) begin
                    o_ctrl.alu_src_b = SB_IMM;
                    o_ctrl.reg_dst   = RD_RT;
                end else begin
                    o_ctrl.alu_src_b = SB_REG;
                    o_ctrl.reg_dst   = RD_RD;
                end
                o_ctrl.alu_out_w = (i_step == '0);
                if (i_step == ALU_LAST) begin
                    o_ctrl.reg_w    = 1'b1;
                    o_ctrl.data_src = DS_ALUOUT;
                end
            end
            ST_SLT: begin
                o_ctrl.alu_op   = ALU_SLT;
                o_ctrl.data_src = DS_SLT;
                o_ctrl.reg_w    = (i_step == '0);
            end
            ST_JR: begin
                o_ctrl.pc_w   = 1'b1;
                o_ctrl.alu_op = ALU_PASS;
            end
            ST_BREAK: begin
                // Step back over the PC increment once, then stay quiet
                if (i_step == '0) begin
                    o_ctrl.pc_w      = 1'b1;
                    o_ctrl.alu_op    = ALU_SUB;
                    o_ctrl.alu_src_b = SB_FOUR;
                end
            end
            ST_SHIFT_SETUP: begin
                o_ctrl.shift_op = SH_LOAD;
            end
            ST_SLL, ST_SRL, ST_SRA: begin
                if (i_step == SHIFT_LAST) begin
                    o_ctrl.shift_op = SH_NOP;
                    o_ctrl.reg_w    = 1'b1;
                    o_ctrl.data_src = DS_SHIFT;
                end else begin
                    o_ctrl.shift_op = shift_dir;
                end
            end
            ST_SW: begin
                o_ctrl.i_or_d    = 3'd1;
                o_ctrl.alu_src_b = SB_IMM;
                o_ctrl.mem_w     = (i_step == MEM_LAST);
            end
            ST_LW: begin
                o_ctrl.i_or_d = 3'd1;
                o_ctrl.mdr_w  = 1'b1;
                if (i_step == MEM_LAST) begin
                    o_ctrl.reg_w    = 1'b1;
                    o_ctrl.data_src = DS_MDR;
                    o_ctrl.reg_dst  = RD_RT;
                end
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

// File: logic/ctrl_unit.sv
`timescale 1ns/1ps

module ctrl_unit import ctrl_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  instr_fields_t i_fields,
    output ctrl_word_t    o_ctrl,
    output logic          o_cpu_reset
);

    instr_class_e instr_class;
    ctrl_state_e  state;
    step_t        step;

    instr_decoder u_decoder (
        .i_fields (i_fields),
        .o_class  (instr_class)
    );

    step_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .i_class     (instr_class),
        .o_state     (state),
        .o_step      (step),
        .o_cpu_reset (o_cpu_reset)
    );

    ctrl_word_encoder u_encoder (
        .i_state (state),
        .i_step  (step),
        .o_ctrl  (o_ctrl)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_reset
);

    // Remaining reset cycles, reloaded on request
    int unsigned hold = 3;

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    always @(posedge o_clk) begin
        if (i_rst_req) begin
            hold <= 3;
        end else if (hold != 0) begin
            hold <= hold - 1;
        end
    end

    assign o_reset = (hold != 0);

endmodule

// File: testbench/ctrl_unit_sva.sv
`timescale 1ns/1ps

module ctrl_unit_sva import ctrl_pkg::*; (
    input logic        clk,
    input logic        reset,
    input ctrl_word_t  i_ctrl,
    input ctrl_state_e i_state,
    input logic        i_cpu_reset
);

    // Instruction, memory and register writes never overlap
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({i_ctrl.ir_w, i_ctrl.mem_w, i_ctrl.reg_w}))
        else $error("more than one of ir_w, mem_w, reg_w high");

    assert property (@(posedge clk) disable iff (reset)
        (i_state == ST_RESET) |=> !i_cpu_reset)
        else $error("o_cpu_reset still high after ST_RESET");

    // Decode takes at least 3 cycles after every fetch
    assert property (@(posedge clk) disable iff (reset)
        i_ctrl.ir_w |=> !i_ctrl.ir_w [*3])
        else $error("ir_w repeated within 3 cycles");

endmodule

bind ctrl_unit ctrl_unit_sva sva0 (
    .clk         (clk),
    .reset       (reset),
    .i_ctrl      (o_ctrl),
    .i_state     (state),
    .i_cpu_reset (o_cpu_reset)
);

// File: testbench/ctrl_unit_tb.sv
`timescale 1ns/1ps

`include "ctrl_config.svh"

module ctrl_unit_tb import ctrl_pkg::*; ();

    localparam logic [15:0] SEED = 16'd31384;

    logic          clk;
    logic          reset;
    logic          rst_req;
    instr_fields_t i_fields;
    ctrl_word_t    o_ctrl;
    logic          o_cpu_reset;
    logic [15:0]   lfsr;

    tb_clock clk_gen (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_reset   (reset)
    );

    ctrl_unit dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_fields    (i_fields),
        .o_ctrl      (o_ctrl),
        .o_cpu_reset (o_cpu_reset)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // Index 0..11 over every class except break
    function automatic instr_class_e class_from_index(input int k);
        int idx;
        idx = (k >= int'(CL_BREAK)) ? k + 1 : k;
        return instr_class_e'(idx);
    endfunction

    function automatic instr_fields_t fields_for(input instr_class_e cls);
        case (cls)
            CL_ADD:   return {`OP_RTYPE, `FN_ADD};
            CL_SUB:   return {`OP_RTYPE, `FN_SUB};
            CL_AND:   return {`OP_RTYPE, `FN_AND};
            CL_SLT:   return {`OP_RTYPE, `FN_SLT};
            CL_ADDI:  return {`OP_ADDI, 6'h15};
            CL_JR:    return {`OP_RTYPE, `FN_JR};
            CL_BREAK: return {`OP_RTYPE, `FN_BREAK};
            CL_SLL:   return {`OP_RTYPE, `FN_SLL};
            CL_SRL:   return {`OP_RTYPE, `FN_SRL};
            CL_SRA:   return {`OP_RTYPE, `FN_SRA};
            CL_LW:    return {`OP_LW, 6'h2e};
            CL_SW:    return {`OP_SW, 6'h09};
            default:  return {6'h3f, 6'h00};
        endcase
    endfunction

    function automatic int exec_len(input instr_class_e cls);
        case (cls)
            CL_ADD, CL_SUB, CL_AND, CL_ADDI: return `ALU_STEPS;
            CL_SLT:                          return `ALU_STEPS - 1;
            CL_JR, CL_BREAK:                 return 1;
            CL_SLL, CL_SRL, CL_SRA:          return 1 + `SHIFT_STEPS;
            CL_LW, CL_SW:                    return `MEM_STEPS;
            default:                         return 0;
        endcase
    endfunction

    // Cycle 0 is the ir_w cycle, the last index is fetch step 2 of the next instruction
    function automatic ctrl_word_t expected_word(input instr_class_e cls, input int idx);
        ctrl_word_t w;
        int         e;
        w = '0;
        e = idx - 4;
        if (idx == 0) begin
            w.ir_w      = 1'b1;
            w.pc_w      = 1'b1;
            w.pc_src    = PC_ALU;
            w.alu_src_b = SB_FOUR;
            w.alu_op    = ALU_ADD;
        end else if (idx == 1) begin
            w.reg_ab_w  = 1'b1;
            w.alu_out_w = 1'b1;
            w.alu_src_b = SB_BRANCH;
        end else if (e >= 0 && e < exec_len(cls)) begin
            case (cls)
                CL_ADD, CL_SUB, CL_AND, CL_ADDI: begin
                    w.alu_src_a = 1'b1;
                    w.alu_src_b = (cls == CL_ADDI) ? SB_IMM : SB_REG;
                    w.reg_dst   = (cls == CL_ADDI) ? RD_RT : RD_RD;
                    w.alu_op    = (cls == CL_SUB) ? ALU_SUB :
                                  (cls == CL_AND) ? ALU_AND : ALU_ADD;
                    w.alu_out_w = (e == 0);
                    w.reg_w     = (e == 2);
                    w.data_src  = (e == 2) ? DS_ALUOUT : 3'd0;
                end
                CL_SLT: begin
                    w.alu_op   = ALU_SLT;
                    w.data_src = DS_SLT;
                    w.reg_w    = (e == 0);
                end
                CL_JR: begin
                    w.pc_w   = 1'b1;
                    w.alu_op = ALU_PASS;
                end
                CL_BREAK: begin
                    w.pc_w      = 1'b1;
                    w.alu_op    = ALU_SUB;
                    w.alu_src_b = SB_FOUR;
                end
                CL_SLL, CL_SRL, CL_SRA: begin
                    if (e == 0) begin
                        w.shift_op = SH_LOAD;
                    end else if (e == 1) begin
                        w.shift_op = (cls == CL_SRL) ? SH_RIGHT_LOG :
                                     (cls == CL_SRA) ? SH_RIGHT_ARITH : SH_LEFT;
                    end else begin
                        w.reg_w    = 1'b1;
                        w.data_src = DS_SHIFT;
                    end
                end
                CL_SW: begin
                    w.i_or_d    = 3'd1;
                    w.alu_src_b = SB_IMM;
                    w.mem_w     = (e == 3);
                end
                CL_LW: begin
                    w.i_or_d = 3'd1;
                    w.mdr_w  = 1'b1;
                    if (e == 3) begin
                        w.reg_w    = 1'b1;
                        w.data_src = DS_MDR;
                        w.reg_dst  = RD_RT;
                    end
                end
                default: begin
                    w = '0;
                end
            endcase
        end
        return w;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reset(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic wait_ir_w(input int limit);
        int waited;
        waited = 0;
        while (!o_ctrl.ir_w) begin
            if (waited >= limit) begin
                report_failure("ir_w did not appear when the next fetch was due");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Called at a falling edge while reset is high
    task automatic reset_sync();
        int waited;
        int count;
        waited = 0;
        while (reset) begin
            check_reset("reset held", 1'b1, o_cpu_reset);
            check_ctrl("reset held", '0, o_ctrl);
            @(negedge clk);
            waited++;
            if (waited > 10) begin
                report_failure("reset never released");
            end
        end
        count = 1;
        check_reset("ST_RESET", 1'b1, o_cpu_reset);
        check_ctrl("ST_RESET", '0, o_ctrl);
        while (!o_ctrl.ir_w) begin
            @(negedge clk);
            count++;
            if (count > 10) begin
                report_failure("no ir_w after reset");
            end
        end
        check_count("first ir_w", 5, count);
        check_reset("after ST_RESET", 1'b0, o_cpu_reset);
    endtask

    task automatic run_instr(input instr_class_e cls);
        int period;
        period = exec_len(cls) + 8;
        wait_ir_w(1);
        for (int idx = 0; idx < period; idx++) begin
            if (idx > 0) begin
                @(negedge clk);
            end
            check_ctrl($sformatf("%s cycle %0d", cls.name(), idx),
                       expected_word(cls, idx), o_ctrl);
            check_reset($sformatf("%s cpu_reset", cls.name()), 1'b0, o_cpu_reset);
        end
    endtask

    task automatic run_break();
        wait_ir_w(1);
        for (int idx = 0; idx < 25; idx++) begin
            if (idx > 0) begin
                @(negedge clk);
            end
            check_ctrl($sformatf("CL_BREAK cycle %0d", idx),
                       expected_word(CL_BREAK, idx), o_ctrl);
        end
    endtask

    task automatic apply_reset();
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
    endtask

    initial begin
        #100000;
        $display("Simulation ran past its time limit");
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        instr_class_e seq[$];
        int           v;
        rst_req = 1'b0;
        lfsr = SEED;
        for (int k = 0; k < 12; k++) begin
            seq.push_back(class_from_index(k));
        end
        for (int n = 0; n < 30; n++) begin
            take_bits(4, v);
            seq.push_back(class_from_index(v % 12));
        end
        i_fields = fields_for(seq[0]);
        @(negedge clk);
        reset_sync();
        foreach (seq[i]) begin
            run_instr(seq[i]);
            if (i + 1 < seq.size()) begin
                i_fields = fields_for(seq[i + 1]);
            end else begin
                i_fields = fields_for(CL_BREAK);
            end
        end
        run_break();
        // Only reset leaves break
        i_fields = fields_for(CL_ADD);
        apply_reset();
        reset_sync();
        run_instr(CL_ADD);
        i_fields = fields_for(CL_SW);
        run_instr(CL_SW);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/ctrl_pkg.sv
logic/instr_decoder.sv
logic/step_sequencer.sv
logic/ctrl_word_encoder.sv
logic/ctrl_unit.sv
testbench/tb_clock.sv
testbench/ctrl_unit_sva.sv
testbench/ctrl_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ctrl_unit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
